/* logic/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  typedef logic [4:0] reg_idx_t;

  // {funct7[5], funct3} of the OP encoding
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_SRA  = 4'b1101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // word width for LW and SW
  localparam logic [2:0] F3_WORD = 3'b010;
  // SRL/SRA and SRLI/SRAI
  localparam logic [2:0] F3_SR   = 3'b101;

endpackage

`default_nettype wire

/* logic/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [3:0]  strb_t;

  localparam addr_t DEFAULT_RESET_PC   = 32'h0000_0000;
  localparam addr_t DEFAULT_TIMER_BASE = 32'h0200_0000;

  // bytes decoded by the timer
  localparam int unsigned TIMER_WINDOW = 16;

  localparam logic [3:0] MTIME_LO    = 4'h0;
  localparam logic [3:0] MTIME_HI    = 4'h4;
  localparam logic [3:0] MTIMECMP_LO = 4'h8;
  localparam logic [3:0] MTIMECMP_HI = 4'hC;

endpackage

`default_nettype wire

/* logic/register.sv */
`timescale 1ns/1ps
`default_nettype none

module register (
  input  wire logic                 clock,
  input  wire logic                 arst_n,
  input  wire rv_isa_pkg::reg_idx_t rs1_idx,
  input  wire rv_isa_pkg::reg_idx_t rs2_idx,
  output soc_map_pkg::word_t        rs1_data,
  output soc_map_pkg::word_t        rs2_data,
  input  wire logic                 wr_en,
  input  wire rv_isa_pkg::reg_idx_t wr_idx,
  input  wire soc_map_pkg::word_t   wr_data
);
  import soc_map_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // x0 is hardwired to zero
  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

/* logic/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire rv_isa_pkg::alu_op_t op,
  input  wire soc_map_pkg::word_t  a,
  input  wire soc_map_pkg::word_t  b,
  output soc_map_pkg::word_t       result,
  input  wire logic [2:0]          branch_funct3,
  output logic                     branch_taken
);
  import rv_isa_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign lt_s  = $signed(a) < $signed(b);
  assign lt_u  = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result = {31'b0, lt_s};
      ALU_SLTU: result = {31'b0, lt_u};
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = $signed(a) >>> shamt;
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      default:  result = a + b;
    endcase
  end

  // compare shares the less-than terms with slt/sltu
  always_comb begin
    case (branch_funct3)
      F3_BEQ:  branch_taken = (a == b);
      F3_BNE:  branch_taken = (a != b);
      F3_BLT:  branch_taken = lt_s;
      F3_BGE:  branch_taken = !lt_s;
      F3_BLTU: branch_taken = lt_u;
      F3_BGEU: branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu #(
  parameter soc_map_pkg::addr_t reset_pc = soc_map_pkg::DEFAULT_RESET_PC
) (
  input  wire logic               clock,
  input  wire logic               arst_n,
  output logic                    imemory_valid,
  output soc_map_pkg::addr_t      imemory_addr,
  input  wire soc_map_pkg::word_t imemory_rdata,
  input  wire logic               imemory_ready,
  output logic                    dmemory_valid,
  output soc_map_pkg::addr_t      dmemory_addr,
  output soc_map_pkg::word_t      dmemory_wdata,
  output soc_map_pkg::strb_t      dmemory_wstrb,
  input  wire soc_map_pkg::word_t dmemory_rdata,
  input  wire logic               dmemory_ready
);
  import rv_isa_pkg::*;
  import soc_map_pkg::*;

  typedef enum logic [1:0] {
    FETCH,
    EXECUTE,
    MEMORY
  } state_t;

  state_t     state;
  addr_t      pc;
  word_t      ir;

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   rd;
  reg_idx_t   rs1;
  reg_idx_t   rs2;

  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  word_t      rs1_data;
  word_t      rs2_data;
  alu_op_t    alu_op;
  word_t      alu_a;
  word_t      alu_b;
  word_t      alu_result;
  logic       branch_taken;

  addr_t      pc_plus4;
  addr_t      branch_target;
  addr_t      next_pc;
  logic       wb_en;
  word_t      wb_data;
  logic       is_load;
  logic       is_store;

  logic       fetch_done;
  logic       mem_done;
  logic       rf_wr_en;
  word_t      rf_wr_data;

  assign opcode = ir[6:0];
  assign rd     = ir[11:7];
  assign funct3 = ir[14:12];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};
  assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

  assign pc_plus4      = pc + 32'd4;
  assign branch_target = pc + imm_b;

  assign fetch_done = imemory_valid && imemory_ready;
  assign mem_done   = dmemory_valid && dmemory_ready;

  always_comb begin
    alu_op   = ALU_ADD;
    alu_a    = rs1_data;
    alu_b    = imm_i;
    wb_en    = 1'b0;
    wb_data  = alu_result;
    next_pc  = pc_plus4;
    is_load  = 1'b0;
    is_store = 1'b0;
    case (opcode)
      OPC_LUI: begin
        alu_a = '0;
        alu_b = imm_u;
        wb_en = 1'b1;
      end
      OPC_AUIPC: begin
        alu_a = pc;
        alu_b = imm_u;
        wb_en = 1'b1;
      end
      OPC_JAL: begin
        alu_a   = pc;
        alu_b   = imm_j;
        wb_en   = 1'b1;
        wb_data = pc_plus4;
        next_pc = alu_result;
      end
      OPC_JALR: begin
        wb_en   = 1'b1;
        wb_data = pc_plus4;
        next_pc = {alu_result[31:1], 1'b0};
      end
      OPC_BRANCH: begin
        alu_b = rs2_data;
        if (branch_taken) begin
          next_pc = branch_target;
        end
      end
      OPC_LOAD: begin
        is_load = (funct3 == F3_WORD);
      end
      OPC_STORE: begin
        alu_b    = imm_s;
        is_store = (funct3 == F3_WORD);
      end
      OPC_OP_IMM: begin
        // bit 30 is part of the immediate except for right shifts
        alu_op = {(funct3 == F3_SR) && ir[30], funct3};
        wb_en  = 1'b1;
      end
      OPC_OP: begin
        alu_op = {ir[30], funct3};
        alu_b  = rs2_data;
        wb_en  = 1'b1;
      end
      default: begin
        wb_en = 1'b0;
      end
    endcase
  end

  // load data lands at the data handshake and everything else in EXECUTE
  assign rf_wr_en   = ((state == EXECUTE) && wb_en) || ((state == MEMORY) && is_load && mem_done);
  assign rf_wr_data = (state == MEMORY) ? dmemory_rdata : wb_data;

  register u_register (
    .clock    (clock),
    .arst_n   (arst_n),
    .rs1_idx  (rs1),
    .rs2_idx  (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (rf_wr_en),
    .wr_idx   (rd),
    .wr_data  (rf_wr_data)
  );

  alu u_alu (
    .op            (alu_op),
    .a             (alu_a),
    .b             (alu_b),
    .result        (alu_result),
    .branch_funct3 (funct3),
    .branch_taken  (branch_taken)
  );

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state         <= FETCH;
      pc            <= reset_pc;
      imemory_valid <= 1'b0;
      dmemory_valid <= 1'b0;
      dmemory_wstrb <= '0;
    end else begin
      case (state)
        FETCH: begin
          if (fetch_done) begin
            imemory_valid <= 1'b0;
            state         <= EXECUTE;
          end else begin
            // also raises the first request out of reset
            imemory_valid <= 1'b1;
          end
        end
        EXECUTE: begin
          pc <= next_pc;
          if (is_load || is_store) begin
            dmemory_valid <= 1'b1;
            dmemory_wstrb <= {4{is_store}};
            state         <= MEMORY;
          end else begin
            imemory_valid <= 1'b1;
            state         <= FETCH;
          end
        end
        MEMORY: begin
          if (mem_done) begin
            dmemory_valid <= 1'b0;
            dmemory_wstrb <= '0;
            imemory_valid <= 1'b1;
            state         <= FETCH;
          end
        end
        default: begin
          state <= FETCH;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_done) begin
      ir <= imemory_rdata;
    end
    if (state == EXECUTE) begin
      dmemory_addr  <= alu_result;
      dmemory_wdata <= rs2_data;
    end
  end

  assign imemory_addr = pc;

endmodule

`default_nettype wire

/* logic/timer.sv */
`timescale 1ns/1ps
`default_nettype none

module timer (
  input  wire logic               clock,
  input  wire logic               arst_n,
  input  wire logic               valid,
  input  wire logic [3:0]         offset,
  input  wire soc_map_pkg::word_t wdata,
  input  wire soc_map_pkg::strb_t wstrb,
  output soc_map_pkg::word_t      rdata,
  output logic                    ready,
  output logic                    mtip
);
  import soc_map_pkg::*;

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic        wr_accept;

  function automatic word_t merge_bytes(word_t old_val, word_t new_val, strb_t strb);
    word_t merged;
    merged = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return merged;
  endfunction

  assign wr_accept = valid && ready && (wstrb != '0);

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtime    <= '0;
      mtimecmp <= '1;
      ready    <= 1'b0;
      mtip     <= 1'b0;
    end else begin
      // single-cycle answer that drops once the access completes
      ready <= valid && !ready;
      mtip  <= (mtime >= mtimecmp);
      mtime <= mtime + 64'd1;
      if (wr_accept) begin
        case (offset)
          MTIME_LO:    mtime[31:0]     <= merge_bytes(mtime[31:0], wdata, wstrb);
          MTIME_HI:    mtime[63:32]    <= merge_bytes(mtime[63:32], wdata, wstrb);
          MTIMECMP_LO: mtimecmp[31:0]  <= merge_bytes(mtimecmp[31:0], wdata, wstrb);
          MTIMECMP_HI: mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], wdata, wstrb);
          default:     mtimecmp        <= mtimecmp;
        endcase
      end
    end
  end

  always_comb begin
    case (offset)
      MTIME_LO:    rdata = mtime[31:0];
      MTIME_HI:    rdata = mtime[63:32];
      MTIMECMP_LO: rdata = mtimecmp[31:0];
      MTIMECMP_HI: rdata = mtimecmp[63:32];
      default:     rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/rv_soc.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_soc #(
  parameter soc_map_pkg::addr_t reset_pc   = soc_map_pkg::DEFAULT_RESET_PC,
  parameter soc_map_pkg::addr_t timer_base = soc_map_pkg::DEFAULT_TIMER_BASE
) (
  input  wire logic               clock,
  input  wire logic               arst_n,
  output logic                    imemory_valid,
  output soc_map_pkg::addr_t      imemory_addr,
  input  wire soc_map_pkg::word_t imemory_rdata,
  input  wire logic               imemory_ready,
  output logic                    dmemory_valid,
  output soc_map_pkg::addr_t      dmemory_addr,
  output soc_map_pkg::word_t      dmemory_wdata,
  output soc_map_pkg::strb_t      dmemory_wstrb,
  input  wire soc_map_pkg::word_t dmemory_rdata,
  input  wire logic               dmemory_ready,
  output logic                    mtip
);
  import soc_map_pkg::*;

  logic  core_dvalid;
  addr_t core_daddr;
  word_t core_dwdata;
  strb_t core_dwstrb;
  word_t core_drdata;
  logic  core_dready;

  addr_t timer_rel;
  logic  timer_sel;
  word_t timer_rdata;
  logic  timer_ready;

  // one subtraction gives both the window hit and the register offset
  assign timer_rel = core_daddr - timer_base;
  assign timer_sel = timer_rel < addr_t'(TIMER_WINDOW);

  assign dmemory_valid = core_dvalid && !timer_sel;
  assign dmemory_addr  = core_daddr;
  assign dmemory_wdata = core_dwdata;
  assign dmemory_wstrb = core_dwstrb;

  assign core_drdata = timer_sel ? timer_rdata : dmemory_rdata;
  assign core_dready = timer_sel ? timer_ready : dmemory_ready;

  cpu #(
    .reset_pc (reset_pc)
  ) u_cpu (
    .clock         (clock),
    .arst_n        (arst_n),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (core_dvalid),
    .dmemory_addr  (core_daddr),
    .dmemory_wdata (core_dwdata),
    .dmemory_wstrb (core_dwstrb),
    .dmemory_rdata (core_drdata),
    .dmemory_ready (core_dready)
  );

  timer u_timer (
    .clock  (clock),
    .arst_n (arst_n),
    .valid  (core_dvalid && timer_sel),
    .offset (timer_rel[3:0]),
    .wdata  (core_dwdata),
    .wstrb  (core_dwstrb),
    .rdata  (timer_rdata),
    .ready  (timer_ready),
    .mtip   (mtip)
  );

endmodule

`default_nettype wire

/* tb/rv_soc_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_soc_properties (
  input wire logic               clock,
  input wire logic               arst_n,
  input wire logic               imemory_valid,
  input wire soc_map_pkg::addr_t imemory_addr,
  input wire logic               imemory_ready,
  input wire logic               dmemory_valid,
  input wire soc_map_pkg::addr_t dmemory_addr,
  input wire soc_map_pkg::word_t dmemory_wdata,
  input wire soc_map_pkg::strb_t dmemory_wstrb,
  input wire logic               dmemory_ready,
  input wire soc_map_pkg::word_t ir
);
  import rv_isa_pkg::*;

  // a request stays up and unchanged until ready
  assert property (@(posedge clock) disable iff (!arst_n)
    imemory_valid && !imemory_ready |=> imemory_valid && $stable(imemory_addr))
    else $error("instruction request dropped or changed before ready");

  assert property (@(posedge clock) disable iff (!arst_n)
    dmemory_valid && !dmemory_ready |=> dmemory_valid && $stable(dmemory_addr)
      && $stable(dmemory_wdata) && $stable(dmemory_wstrb))
    else $error("data request dropped or changed before ready");

  // a load never carries a write strobe
  assert property (@(posedge clock) disable iff (!arst_n)
    dmemory_valid && (ir[6:0] == OPC_LOAD) |-> dmemory_wstrb == 4'h0)
    else $error("write strobe set on a load");

  // strobe idles at zero between requests
  assert property (@(posedge clock) disable iff (!arst_n)
    !dmemory_valid |-> dmemory_wstrb == 4'h0)
    else $error("write strobe set without a request");

  assert property (@(posedge clock) !arst_n |-> !imemory_valid && !dmemory_valid)
    else $error("bus valid high during reset");

endmodule

bind cpu rv_soc_properties u_bus_props (
  .clock         (clock),
  .arst_n        (arst_n),
  .imemory_valid (imemory_valid),
  .imemory_addr  (imemory_addr),
  .imemory_ready (imemory_ready),
  .dmemory_valid (dmemory_valid),
  .dmemory_addr  (dmemory_addr),
  .dmemory_wdata (dmemory_wdata),
  .dmemory_wstrb (dmemory_wstrb),
  .dmemory_ready (dmemory_ready),
  .ir            (ir)
);

`default_nettype wire

/* tb/rv_soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_soc_tb;
  import rv_isa_pkg::*;
  import soc_map_pkg::*;

  localparam addr_t TB_RESET_PC   = DEFAULT_RESET_PC;
  localparam addr_t TB_TIMER_BASE = DEFAULT_TIMER_BASE;
  localparam int    MAX_DELAY     = 3;

  logic  clock;
  logic  arst_n;
  logic  imemory_valid;
  addr_t imemory_addr;
  word_t imemory_rdata;
  logic  imemory_ready;
  logic  dmemory_valid;
  addr_t dmemory_addr;
  word_t dmemory_wdata;
  strb_t dmemory_wstrb;
  word_t dmemory_rdata;
  logic  dmemory_ready;
  logic  mtip;

  logic [31:0] lfsr_state;
  word_t       imem [256];
  int          prog_len;
  word_t       dmem [addr_t];
  word_t       model_mem [addr_t];

  // expected behavior from the instruction model
  addr_t       exp_pc [$];
  addr_t       final_pc;
  addr_t       exp_addr [$];
  strb_t       exp_wstrb [$];
  word_t       exp_wdata [$];
  logic        exp_known [$];
  word_t       timer_samples [$];

  int          error_count;
  int          i_wait;
  int          d_wait;
  logic        i_hs;
  logic        d_hs;
  logic        timer_wr_hs;
  int          cmp_writes;
  int          since_write;
  int          mtip_checked;
  addr_t       pc_now;
  addr_t       acc_addr;
  strb_t       acc_strb;
  word_t       acc_data;
  logic        acc_known;

  rv_soc #(
    .reset_pc   (TB_RESET_PC),
    .timer_base (TB_TIMER_BASE)
  ) u_rv_soc (
    .clock         (clock),
    .arst_n        (arst_n),
    .imemory_valid (imemory_valid),
    .imemory_addr  (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr  (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready),
    .mtip          (mtip)
  );

  // timer write completing on the core side of the data split
  assign timer_wr_hs = u_rv_soc.core_dvalid && u_rv_soc.core_dready
                       && (u_rv_soc.core_dwstrb != '0) && in_timer(u_rv_soc.core_daddr);

  always #20 clock = ~clock;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic reg_idx_t pick_reg();
    logic [31:0] r;
    r = rand_bits(4);
    return reg_idx_t'(1 + (r % 15));
  endfunction

  function automatic word_t fill_word(input addr_t a);
    return a ^ 32'hc3a5_0f96;
  endfunction

  function automatic logic in_timer(input addr_t a);
    return (a >= TB_TIMER_BASE) && (a < TB_TIMER_BASE + TIMER_WINDOW);
  endfunction

  function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd,
                                  input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                  input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic emit(input word_t w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  task automatic emit_random_op();
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    rd  = pick_reg();
    rs1 = pick_reg();
    r   = rand_bits(3);
    f3  = r[2:0];
    r   = rand_bits(1);
    alt = r[0];
    r   = rand_bits(1);
    if (r[0]) begin
      if (f3 != 3'd0 && f3 != F3_SR) begin
        alt = 1'b0;
      end
      emit({1'b0, alt, 5'b0, pick_reg(), rs1, f3, rd, OPC_OP});
    end else if (f3 == 3'd1 || f3 == F3_SR) begin
      if (f3 == 3'd1) begin
        alt = 1'b0;
      end
      r = rand_bits(5);
      emit(enc_i({1'b0, alt, 5'b0, r[4:0]}, rs1, f3, rd, OPC_OP_IMM));
    end else begin
      r = rand_bits(12);
      emit(enc_i(r[11:0], rs1, f3, rd, OPC_OP_IMM));
    end
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [2:0]  br_f3 [6];
    br_f3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    prog_len = 0;
    for (int i = 1; i <= 6; i++) begin
      r = rand_bits(20);
      emit({r[19:0], reg_idx_t'(i), OPC_LUI});
      r = rand_bits(12);
      emit(enc_i(r[11:0], reg_idx_t'(i), 3'd0, reg_idx_t'(i), OPC_OP_IMM));
    end
    for (int k = 0; k < 20; k++) begin
      if (k % 5 == 4) begin
        // forward branch over one operation
        r = rand_bits(3);
        emit(enc_b(13'd8, pick_reg(), pick_reg(), br_f3[r % 6]));
      end
      emit_random_op();
    end
    // call and return through JAL/JALR
    emit(enc_j(21'd12, 5'd16));
    emit(enc_j(21'd12, 5'd0));
    emit(enc_i(12'd1, 5'd1, 3'd0, 5'd1, OPC_OP_IMM));
    emit(enc_i(12'd0, 5'd16, 3'd0, 5'd17, OPC_JALR));
    emit({20'h00001, 5'd24, OPC_LUI});
    for (int i = 1; i <= 15; i++) begin
      emit(enc_s(12'(4 * i), reg_idx_t'(i), 5'd24));
    end
    emit(enc_i(12'd4, 5'd24, F3_WORD, 5'd18, OPC_LOAD));
    emit(enc_s(12'h100, 5'd18, 5'd24));
    emit({TB_TIMER_BASE[31:12], 5'd25, OPC_LUI});
    emit(enc_i(12'(MTIME_LO), 5'd25, F3_WORD, 5'd20, OPC_LOAD));
    emit(enc_s(12'h104, 5'd20, 5'd24));
    emit(enc_i(12'(MTIME_LO), 5'd25, F3_WORD, 5'd21, OPC_LOAD));
    emit(enc_s(12'h108, 5'd21, 5'd24));
    emit(enc_s(12'(MTIMECMP_HI), 5'd0, 5'd25));
    emit(enc_s(12'(MTIMECMP_LO), 5'd0, 5'd25));
    emit(enc_j(21'd0, 5'd0));
  endtask

  function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
    word_t res;
    case (f3)
      3'd0: res = alt ? a - b : a + b;
      3'd1: res = a << b[4:0];
      3'd2: res = {31'b0, $signed(a) < $signed(b)};
      3'd3: res = {31'b0, a < b};
      3'd4: res = a ^ b;
      3'd5: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      3'd6: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      F3_BEQ:  return a == b;
      F3_BNE:  return a != b;
      F3_BLT:  return $signed(a) < $signed(b);
      F3_BGE:  return $signed(a) >= $signed(b);
      F3_BLTU: return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic run_model();
    word_t    x [32];
    logic     kn [32];
    addr_t    pc;
    addr_t    npc;
    addr_t    ea;
    word_t    w;
    word_t    val;
    logic     wr;
    logic     val_known;
    reg_idx_t rd;
    word_t    imm_i;
    int       steps;
    for (int i = 0; i < 32; i++) begin
      x[i]  = '0;
      kn[i] = 1'b1;
    end
    pc    = TB_RESET_PC;
    steps = 0;
    while (steps < 1000) begin
      w         = imem[pc[9:2]];
      rd        = w[11:7];
      imm_i     = {{20{w[31]}}, w[31:20]};
      npc       = pc + 4;
      wr        = 1'b1;
      val_known = 1'b1;
      exp_pc.push_back(pc);
      if (w == enc_j(21'd0, 5'd0)) begin
        final_pc = pc;
        break;
      end
      case (w[6:0])
        OPC_LUI: val = {w[31:12], 12'b0};
        OPC_AUIPC: val = pc + {w[31:12], 12'b0};
        OPC_JAL: begin
          val = pc + 4;
          npc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end
        OPC_JALR: begin
          val = pc + 4;
          npc = (x[w[19:15]] + imm_i) & ~32'd1;
        end
        OPC_BRANCH: begin
          wr = 1'b0;
          if (branch_ref(w[14:12], x[w[19:15]], x[w[24:20]])) begin
            npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
          end
        end
        OPC_LOAD: begin
          ea = x[w[19:15]] + imm_i;
          if (in_timer(ea)) begin
            val       = '0;
            val_known = 1'b0;
          end else begin
            val = model_mem.exists(ea) ? model_mem[ea] : fill_word(ea);
            exp_addr.push_back(ea);
            exp_wstrb.push_back(4'h0);
            exp_wdata.push_back('0);
            exp_known.push_back(1'b0);
          end
        end
        OPC_STORE: begin
          wr = 1'b0;
          ea = x[w[19:15]] + {{20{w[31]}}, w[31:25], w[11:7]};
          if (!in_timer(ea)) begin
            model_mem[ea] = x[w[24:20]];
            exp_addr.push_back(ea);
            exp_wstrb.push_back(4'hf);
            exp_wdata.push_back(x[w[24:20]]);
            exp_known.push_back(kn[w[24:20]]);
          end
        end
        OPC_OP_IMM: val = alu_ref(w[14:12], (w[14:12] == F3_SR) && w[30], x[w[19:15]], imm_i);
        OPC_OP: val = alu_ref(w[14:12], w[30], x[w[19:15]], x[w[24:20]]);
        default: wr = 1'b0;
      endcase
      if (wr && rd != 5'd0) begin
        x[rd]  = val;
        kn[rd] = val_known;
      end
      pc = npc;
      steps++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  // bus models drive ready and rdata 2 ns after the edge with a random delay
  always begin
    @(posedge clock);
    i_hs = imemory_valid && imemory_ready;
    d_hs = dmemory_valid && dmemory_ready;
    #2;
    if (i_hs) begin
      imemory_ready = 1'b0;
    end
    if (d_hs) begin
      dmemory_ready = 1'b0;
    end
    if (arst_n && imemory_valid && !imemory_ready) begin
      if (i_wait < 0) begin
        i_wait = int'(rand_bits(2)) % (MAX_DELAY + 1);
      end
      if (i_wait == 0) begin
        imemory_rdata = (imemory_addr < 32'd1024) ? imem[imemory_addr[9:2]]
                                                  : fill_word(imemory_addr);
        imemory_ready = 1'b1;
      end
      i_wait--;
    end
    if (arst_n && dmemory_valid && !dmemory_ready) begin
      if (d_wait < 0) begin
        d_wait = int'(rand_bits(2)) % (MAX_DELAY + 1);
      end
      if (d_wait == 0) begin
        dmemory_rdata = dmem.exists(dmemory_addr) ? dmem[dmemory_addr]
                                                  : fill_word(dmemory_addr);
        dmemory_ready = 1'b1;
      end
      d_wait--;
    end
  end

  always @(posedge clock) begin
    if (arst_n) begin
      if (imemory_valid && imemory_ready) begin
        pc_now = (exp_pc.size() > 0) ? exp_pc.pop_front() : final_pc;
        check_equal("imemory_addr", imemory_addr, pc_now);
      end
      if (dmemory_valid && in_timer(dmemory_addr)) begin
        abort_run("a timer access reached the external data port");
      end
      if (dmemory_valid && dmemory_ready) begin
        if (exp_addr.size() == 0) begin
          abort_run("the DUT made a data access that the model did not expect");
        end
        acc_addr  = exp_addr.pop_front();
        acc_strb  = exp_wstrb.pop_front();
        acc_data  = exp_wdata.pop_front();
        acc_known = exp_known.pop_front();
        check_equal("dmemory_addr", dmemory_addr, acc_addr);
        check_equal("dmemory_wstrb", {28'b0, dmemory_wstrb}, {28'b0, acc_strb});
        if (acc_strb != '0) begin
          if (acc_known) begin
            check_equal("dmemory_wdata", dmemory_wdata, acc_data);
          end else begin
            timer_samples.push_back(dmemory_wdata);
          end
          dmem[dmemory_addr] = dmemory_wdata;
        end
      end
      if (cmp_writes == 0) begin
        check_equal("mtip", {31'b0, mtip}, 32'd0);
      end
      if (timer_wr_hs) begin
        cmp_writes++;
        since_write = 0;
      end else if (cmp_writes >= 2) begin
        since_write++;
        if (since_write >= 2) begin
          check_equal("mtip", {31'b0, mtip}, 32'd1);
          mtip_checked++;
        end
      end
    end
  end

  // watchdog sized for the longest fetch and data delays
  initial begin
    #1;
    repeat (prog_len * 60) @(posedge clock);
    abort_run("watchdog timeout, the program did not complete");
  end

  initial begin
    clock         = 1'b0;
    arst_n        = 1'b0;
    imemory_rdata = '0;
    imemory_ready = 1'b0;
    dmemory_rdata = '0;
    dmemory_ready = 1'b0;
    lfsr_state    = 32'h87debad9;
    error_count   = 0;
    i_wait        = -1;
    d_wait        = -1;
    cmp_writes    = 0;
    since_write   = 0;
    mtip_checked  = 0;
    for (int i = 0; i < 256; i++) begin
      imem[i] = fill_word(addr_t'(4 * i));
    end
    build_program();
    run_model();
    repeat (4) @(posedge clock);
    #2;
    arst_n = 1'b1;
    while (exp_pc.size() > 0 || exp_addr.size() > 0 || mtip_checked < 10) begin
      @(posedge clock);
    end
    if (timer_samples.size() != 2) begin
      abort_run("the two mtime samples were not stored out");
    end
    if (timer_samples[1] <= timer_samples[0]) begin
      abort_run("mtime did not increase between the two reads");
    end
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_soc.f */
logic/rv_isa_pkg.sv
logic/soc_map_pkg.sv
logic/register.sv
logic/alu.sv
logic/cpu.sv
logic/timer.sv
logic/rv_soc.sv
tb/rv_soc_properties.sv
tb/rv_soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := rv_soc_tb
FILELIST  := rv_soc.f

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
